//--- logic/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// AXI bus widths
`define AXI_ADDR_W   32                      // Byte address
`define AXI_DATA_W   64                      // One beat is one 64-bit word
`define AXI_STRB_W   8                       // One strobe bit per byte lane
`define AXI_LEN_W    8                       // Beats minus one
`define AXI_BYTE_OFF 3                       // log2 of bytes per beat
`define AXI_WORD_W   (`AXI_ADDR_W - `AXI_BYTE_OFF) // Full word address

// On-chip SRAM geometry, 8 KiB from address 0
`define SRAM_DEPTH   1024                    // Number of 64-bit words
`define SRAM_IDX_W   10                      // Array index width

`endif

//--- logic/axi_pkg.sv
`include "mem_defines.svh"

package axi_pkg;

   ////////////////////
   // Response codes
   ////////////////////

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,                   // Normal access
      RESP_SLVERR = 2'b10                    // Beat outside the SRAM
   } resp_e;

   ////////////////////
   // Channel payloads
   ////////////////////

   // AR and AW share one request layout, INCR bursts of 8-byte beats only
   typedef struct packed {
      logic [`AXI_ADDR_W-1:0] addr;          // Start byte address
      logic [`AXI_LEN_W-1:0]  len;           // Beats minus one
   } ax_t;

   typedef struct packed {
      logic [`AXI_DATA_W-1:0] data;          // Read word
      resp_e                  resp;          // Per-beat status
      logic                   last;          // Final beat of the burst
   } r_t;

   typedef struct packed {
      logic [`AXI_DATA_W-1:0] data;          // Write word
      logic [`AXI_STRB_W-1:0] strb;          // Byte enables
      logic                   last;          // Final beat of the burst
   } w_t;

   typedef struct packed {
      resp_e resp;                           // Burst status
   } b_t;

endpackage

//--- logic/ctrl_pkg.sv
package ctrl_pkg;

   typedef enum logic [1:0] {
      OWN_IDLE,                              // No master holds the read path
      OWN_IFU,                               // Fetch unit owns AR and R
      OWN_MEM                                // Load/store unit owns AR and R
   } rd_owner_e;

   typedef enum logic {
      RD_IDLE,                               // Waiting for AR
      RD_BURST                               // Streaming beats
   } rd_eng_e;

   typedef enum logic [1:0] {
      WR_IDLE,                               // Waiting for AW
      WR_DATA,                               // Taking W beats
      WR_RESP                                // Presenting B
   } wr_eng_e;

endpackage

//--- logic/read_arbiter.sv
`timescale 1ns/10ps

module read_arbiter (
   input  logic         clk,
   input  logic         rst,

   // Fetch and mem masters, AR side
   input  axi_pkg::ax_t ar_ifu,
   input  axi_pkg::ax_t ar_mem,
   input  logic         arvalid_ifu,
   input  logic         arvalid_mem,
   output logic         arready_ifu,
   output logic         arready_mem,

   // Fetch and mem masters, R side
   output axi_pkg::r_t  r_ifu,
   output axi_pkg::r_t  r_mem,
   output logic         rvalid_ifu,
   output logic         rvalid_mem,
   input  logic         rready_ifu,
   input  logic         rready_mem,

   // Slave side
   output axi_pkg::ax_t ar,
   output logic         arvalid,
   input  logic         arready,
   input  axi_pkg::r_t  r,
   input  logic         rvalid,
   output logic         rready
);

   ctrl_pkg::rd_owner_e state;               // Current owner of the read path
   ctrl_pkg::rd_owner_e state_nxt;
   logic                last_acc;            // Final beat handed to the owner

   assign last_acc = rvalid && rready && r.last;

   ////////////////////
   // Ownership FSM
   ////////////////////

   always_comb begin
      state_nxt = state;                     // Hold by default
      case (state)
         ctrl_pkg::OWN_IDLE: begin
            if (arvalid_ifu)                 // Fetch wins ties
               state_nxt = ctrl_pkg::OWN_IFU;
            else if (arvalid_mem)
               state_nxt = ctrl_pkg::OWN_MEM;
         end
         ctrl_pkg::OWN_IFU,
         ctrl_pkg::OWN_MEM: begin
            if (last_acc)                    // Release after the last beat
               state_nxt = ctrl_pkg::OWN_IDLE;
         end
         default: state_nxt = ctrl_pkg::OWN_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst)
         state <= ctrl_pkg::OWN_IDLE;
      else
         state <= state_nxt;
   end

   ////////////////////
   // Channel routing
   ////////////////////

   always_comb begin
      ar          = '0;                      // Idle drives nothing
      arvalid     = 1'b0;
      rready      = 1'b0;
      arready_ifu = 1'b0;
      arready_mem = 1'b0;
      r_ifu       = '0;                      // Non-owner payload reads zero
      r_mem       = '0;
      rvalid_ifu  = 1'b0;
      rvalid_mem  = 1'b0;
      case (state)
         ctrl_pkg::OWN_IFU: begin
            ar          = ar_ifu;
            arvalid     = arvalid_ifu;
            rready      = rready_ifu;
            arready_ifu = arready;
            r_ifu       = r;
            rvalid_ifu  = rvalid;
         end
         ctrl_pkg::OWN_MEM: begin
            ar          = ar_mem;            // Mem side selected on its own state
            arvalid     = arvalid_mem;
            rready      = rready_mem;
            arready_mem = arready;
            r_mem       = r;
            rvalid_mem  = rvalid;
         end
         default: arvalid = 1'b0;
      endcase
   end

endmodule

//--- logic/sram_rd_engine.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module sram_rd_engine (
   input  logic                   clk,
   input  logic                   rst,
   input  axi_pkg::ax_t           ar,
   input  logic                   arvalid,
   output logic                   arready,
   output axi_pkg::r_t            r,
   output logic                   rvalid,
   input  logic                   rready,
   output logic [`SRAM_IDX_W-1:0] rd_word,    // Array read index
   input  logic [`AXI_DATA_W-1:0] rd_data     // Array read word
);

   ctrl_pkg::rd_eng_e       state;
   logic [`AXI_WORD_W-1:0]  word_q;          // Word address of the current beat
   logic [`AXI_LEN_W-1:0]   left_q;          // Beats after the current one
   logic                    in_range;
   logic                    beat_acc;

   assign in_range = word_q < `AXI_WORD_W'(`SRAM_DEPTH);
   assign beat_acc = rvalid && rready;
   assign rd_word  = word_q[`SRAM_IDX_W-1:0]; // Low bits, masked when out of range

   ////////////////////
   // Handshake outputs
   ////////////////////

   assign arready = (state == ctrl_pkg::RD_IDLE);
   assign rvalid  = (state == ctrl_pkg::RD_BURST);

   always_comb begin
      r.data = in_range ? rd_data : '0;     // Zero data outside the SRAM
      r.resp = in_range ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
      r.last = (left_q == '0);
   end

   ////////////////////
   // Burst sequencing
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state  <= ctrl_pkg::RD_IDLE;
         word_q <= '0;
         left_q <= '0;
      end else begin
         case (state)
            ctrl_pkg::RD_IDLE: begin
               if (arvalid) begin            // First beat shows next cycle
                  word_q <= ar.addr[`AXI_ADDR_W-1:`AXI_BYTE_OFF];
                  left_q <= ar.len;
                  state  <= ctrl_pkg::RD_BURST;
               end
            end
            ctrl_pkg::RD_BURST: begin
               if (beat_acc) begin           // Stalled beat holds otherwise
                  if (r.last)
                     state <= ctrl_pkg::RD_IDLE;
                  word_q <= word_q + 1'b1;   // INCR step of one word
                  left_q <= left_q - 1'b1;
               end
            end
            default: state <= ctrl_pkg::RD_IDLE;
         endcase
      end
   end

endmodule

//--- logic/sram_wr_engine.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module sram_wr_engine (
   input  logic                   clk,
   input  logic                   rst,
   input  axi_pkg::ax_t           aw,
   input  logic                   awvalid,
   output logic                   awready,
   input  axi_pkg::w_t            w,
   input  logic                   wvalid,
   output logic                   wready,
   output axi_pkg::b_t            b,
   output logic                   bvalid,
   input  logic                   bready,
   output logic                   wr_en,      // Array write strobe
   output logic [`SRAM_IDX_W-1:0] wr_word,
   output logic [`AXI_DATA_W-1:0] wr_data,
   output logic [`AXI_STRB_W-1:0] wr_strb
);

   ctrl_pkg::wr_eng_e       state;
   logic [`AXI_WORD_W-1:0]  word_q;          // Word address of the next beat
   logic                    err_q;           // Sticky out-of-range flag
   logic                    in_range;
   logic                    beat_acc;

   assign in_range = word_q < `AXI_WORD_W'(`SRAM_DEPTH);
   assign beat_acc = wvalid && wready;

   assign awready = (state == ctrl_pkg::WR_IDLE);
   assign wready  = (state == ctrl_pkg::WR_DATA);
   assign bvalid  = (state == ctrl_pkg::WR_RESP);
   assign b.resp  = err_q ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;

   ////////////////////
   // Array write port
   ////////////////////

   assign wr_en   = beat_acc && in_range;    // Dropped beats never touch the array
   assign wr_word = word_q[`SRAM_IDX_W-1:0];
   assign wr_data = w.data;
   assign wr_strb = w.strb;

   always_ff @(posedge clk) begin
      if (rst) begin
         state  <= ctrl_pkg::WR_IDLE;
         word_q <= '0;
         err_q  <= 1'b0;
      end else begin
         case (state)
            ctrl_pkg::WR_IDLE: begin
               if (awvalid) begin
                  word_q <= aw.addr[`AXI_ADDR_W-1:`AXI_BYTE_OFF];
                  err_q  <= 1'b0;            // Fresh status per burst
                  state  <= ctrl_pkg::WR_DATA;
               end
            end
            ctrl_pkg::WR_DATA: begin
               if (beat_acc) begin
                  word_q <= word_q + 1'b1;
                  err_q  <= err_q || !in_range;
                  if (w.last)                // Burst length set by wlast
                     state <= ctrl_pkg::WR_RESP;
               end
            end
            ctrl_pkg::WR_RESP: begin
               if (bready)
                  state <= ctrl_pkg::WR_IDLE;
            end
            default: state <= ctrl_pkg::WR_IDLE;
         endcase
      end
   end

endmodule

//--- logic/sram_array.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module sram_array (
   input  logic                   clk,
   input  logic [`SRAM_IDX_W-1:0] rd_word,
   output logic [`AXI_DATA_W-1:0] rd_data,
   input  logic                   wr_en,
   input  logic [`SRAM_IDX_W-1:0] wr_word,
   input  logic [`AXI_DATA_W-1:0] wr_data,
   input  logic [`AXI_STRB_W-1:0] wr_strb
);

   logic [`AXI_DATA_W-1:0] mem [`SRAM_DEPTH]; // Contents undefined after reset

   assign rd_data = mem[rd_word];            // Asynchronous read

   // Byte-lane write, one strobe bit per lane
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int i = 0; i < `AXI_STRB_W; i++) begin
            if (wr_strb[i])
               mem[wr_word][i*8 +: 8] <= wr_data[i*8 +: 8];
         end
      end
   end

endmodule

//--- logic/mem_subsys_top.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module mem_subsys_top (
   input  logic         clk,
   input  logic         rst,

   // Fetch unit read port
   input  axi_pkg::ax_t ar_ifu,
   input  logic         arvalid_ifu,
   output logic         arready_ifu,
   output axi_pkg::r_t  r_ifu,
   output logic         rvalid_ifu,
   input  logic         rready_ifu,

   // Mem unit read port
   input  axi_pkg::ax_t ar_mem,
   input  logic         arvalid_mem,
   output logic         arready_mem,
   output axi_pkg::r_t  r_mem,
   output logic         rvalid_mem,
   input  logic         rready_mem,

   // Mem unit write port
   input  axi_pkg::ax_t aw,
   input  logic         awvalid,
   output logic         awready,
   input  axi_pkg::w_t  w,
   input  logic         wvalid,
   output logic         wready,
   output axi_pkg::b_t  b,
   output logic         bvalid,
   input  logic         bready
);

   ////////////////////
   // Internal nets
   ////////////////////

   axi_pkg::ax_t            ar_s;            // Arbiter to read engine
   logic                    arvalid_s;
   logic                    arready_s;
   axi_pkg::r_t             r_s;
   logic                    rvalid_s;
   logic                    rready_s;
   logic [`SRAM_IDX_W-1:0]  rd_word;         // Read engine to array
   logic [`AXI_DATA_W-1:0]  rd_data;
   logic                    wr_en;           // Write engine to array
   logic [`SRAM_IDX_W-1:0]  wr_word;
   logic [`AXI_DATA_W-1:0]  wr_data;
   logic [`AXI_STRB_W-1:0]  wr_strb;

   read_arbiter u_arb (
      .clk, .rst,
      .ar_ifu, .ar_mem, .arvalid_ifu, .arvalid_mem, .arready_ifu, .arready_mem,
      .r_ifu, .r_mem, .rvalid_ifu, .rvalid_mem, .rready_ifu, .rready_mem,
      .ar(ar_s), .arvalid(arvalid_s), .arready(arready_s),
      .r(r_s), .rvalid(rvalid_s), .rready(rready_s)
   );

   sram_rd_engine u_rd (
      .clk, .rst,
      .ar(ar_s), .arvalid(arvalid_s), .arready(arready_s),
      .r(r_s), .rvalid(rvalid_s), .rready(rready_s),
      .rd_word, .rd_data
   );

   sram_wr_engine u_wr (
      .clk, .rst,
      .aw, .awvalid, .awready, .w, .wvalid, .wready, .b, .bvalid, .bready,
      .wr_en, .wr_word, .wr_data, .wr_strb
   );

   sram_array u_ram (
      .clk, .rd_word, .rd_data, .wr_en, .wr_word, .wr_data, .wr_strb
   );

endmodule

//--- test/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen (
   output logic clk
);

   localparam int HALF = 50;                 // 100 ns period

   initial clk = 1'b0;

   always #HALF clk = ~clk;

endmodule

//--- test/read_arbiter_chk.sv
`timescale 1ns/10ps

module read_arbiter_chk (
   input logic                clk,
   input logic                rst,
   input ctrl_pkg::rd_owner_e state,
   input logic                arready_ifu,
   input logic                arready_mem,
   input logic                rvalid_ifu,
   input logic                rvalid_mem
);

   // Read data goes to one master at a time
   one_rvalid: assert property (@(posedge clk) disable iff (rst)
      !(rvalid_ifu && rvalid_mem))
      else $error("rvalid_ifu and rvalid_mem high together");

   // Handover between masters always passes through idle
   via_idle: assert property (@(posedge clk) disable iff (rst)
      (state != $past(state)) |->
         (state == ctrl_pkg::OWN_IDLE || $past(state) == ctrl_pkg::OWN_IDLE))
      else $error("read owner changed without passing through idle");

   // Only the owner sees arready
   owner_arready: assert property (@(posedge clk) disable iff (rst)
      !(state == ctrl_pkg::OWN_IFU && arready_mem) &&
      !(state == ctrl_pkg::OWN_MEM && arready_ifu))
      else $error("arready given to the master that does not own the read path");

endmodule

bind read_arbiter read_arbiter_chk u_chk (
   .clk, .rst, .state, .arready_ifu, .arready_mem, .rvalid_ifu, .rvalid_mem
);

//--- test/tb_top.sv
`timescale 1ns/10ps
`include "mem_defines.svh"

module tb_top;

   localparam int unsigned SEED       = 32'h65e5_88bd;
   localparam int unsigned NUM_BURSTS = 24;  // Every burst issued below
   localparam int unsigned DEPTH      = `SRAM_DEPTH;

   logic clk, rst;
   axi_pkg::ax_t ar_ifu, ar_mem, aw;
   logic         arvalid_ifu, arvalid_mem, arready_ifu, arready_mem;
   axi_pkg::r_t  r_ifu, r_mem;
   logic         rvalid_ifu, rvalid_mem, rready_ifu, rready_mem;
   logic         awvalid, awready, wvalid, wready, bvalid, bready;
   axi_pkg::w_t  w;
   axi_pkg::b_t  b;

   logic [`AXI_DATA_W-1:0] ref_mem [`SRAM_DEPTH]; // Reference copy of the SRAM
   int unsigned checks, errors, test_base;
   int unsigned cyc, mem_rv_cnt;             // Cycle count and mem rvalid samples
   int unsigned ifu_last_cyc, mem_first_cyc; // Ordering marks for contention

   tb_clkgen u_clk (.clk);
   mem_subsys_top uut (.*);

   always @(posedge clk) cyc <= cyc + 1;
   always @(negedge clk) if (rvalid_mem) mem_rv_cnt <= mem_rv_cnt + 1;

   // First mem rvalid seen on the port, whatever the mem model is doing
   always @(negedge clk) if (rvalid_mem && mem_first_cyc == 0) mem_first_cyc = cyc;

   ////////////////////
   // Model and checks
   ////////////////////

   // Fill word depends on every address bit
   function automatic logic [63:0] fill_word(input int unsigned idx);
      return {~idx, idx * 32'h9E37_79B9};
   endfunction

   function automatic logic [63:0] apply_strobe(input logic [63:0] old,
                                                input logic [63:0] data,
                                                input logic [7:0]  strb);
      logic [63:0] res;
      res = old;
      for (int i = 0; i < 8; i++) begin
         if (strb[i])
            res[i*8 +: 8] = data[i*8 +: 8]; // Lane taken from the beat
      end
      return res;
   endfunction

   task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] got);
      checks++;
      assert (exp === got) else begin
         $display("mismatch %s: expected %h, got %h at cycle %0d", name, exp, got, cyc);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      $display("test %-12s %0d errors", name, errors - test_base);
      test_base = errors;
   endtask

   ////////////////////
   // Master models
   ////////////////////

   // Called on a falling edge, returns on one
   task automatic read_burst(input bit ifu, input logic [31:0] addr, input int unsigned len,
                             input bit bp);
      int unsigned beat;
      int unsigned word;
      logic        acc;
      axi_pkg::r_t rb;
      logic [63:0] exp;
      axi_pkg::resp_e exp_resp;
      beat = 0;
      if (ifu) begin
         ar_ifu      = '{addr: addr, len: 8'(len)};
         arvalid_ifu = 1'b1;
      end else begin
         ar_mem      = '{addr: addr, len: 8'(len)};
         arvalid_mem = 1'b1;
      end
      while (!(ifu ? arready_ifu : arready_mem)) @(negedge clk); // Grant, then AR
      @(negedge clk);
      if (ifu)
         arvalid_ifu = 1'b0;
      else
         arvalid_mem = 1'b0;
      while (beat <= len) begin
         if (ifu)
            rready_ifu = bp ? 1'($urandom_range(1)) : 1'b1;
         else
            rready_mem = bp ? 1'($urandom_range(1)) : 1'b1;
         acc = ifu ? (rvalid_ifu && rready_ifu) : (rvalid_mem && rready_mem);
         rb  = ifu ? r_ifu : r_mem;
         if (acc) begin                      // Beat taken on the next rising edge
            word     = (addr >> 3) + beat;
            exp      = (word < DEPTH) ? ref_mem[word[`SRAM_IDX_W-1:0]] : '0;
            exp_resp = (word < DEPTH) ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
            compare(ifu ? "rdata_ifu" : "rdata_mem", exp, rb.data);
            compare(ifu ? "rresp_ifu" : "rresp_mem", 64'(exp_resp), 64'(rb.resp));
            compare(ifu ? "rlast_ifu" : "rlast_mem", 64'(beat == len), 64'(rb.last));
            if (ifu && rb.last)
               ifu_last_cyc = cyc;
            beat++;
         end
         @(negedge clk);
      end
      if (ifu)
         rready_ifu = 1'b0;
      else
         rready_mem = 1'b0;
   endtask

   task automatic write_burst(input logic [31:0] addr, input int unsigned len, input bit bp,
                              input bit fill);
      int unsigned beat;
      int unsigned word;
      bit          fresh;
      bit          err;
      beat    = 0;
      fresh   = 1'b1;
      err     = 1'b0;
      aw      = '{addr: addr, len: 8'(len)};
      awvalid = 1'b1;
      while (!awready) @(negedge clk);
      @(negedge clk);
      awvalid = 1'b0;
      while (beat <= len) begin
         word = (addr >> 3) + beat;
         if (fresh) begin                    // New payload only after a transfer
            w.data = fill ? fill_word(word) : {$urandom, $urandom};
            w.strb = fill ? 8'hFF : 8'($urandom);
            w.last = (beat == len);
            fresh  = 1'b0;
         end
         wvalid = 1'b1;
         if (wready) begin
            if (word < DEPTH)
               ref_mem[word[`SRAM_IDX_W-1:0]] =
                  apply_strobe(ref_mem[word[`SRAM_IDX_W-1:0]], w.data, w.strb);
            else
               err = 1'b1;                   // Beat outside the SRAM is dropped
            beat++;
            fresh = 1'b1;
         end
         @(negedge clk);
      end
      wvalid = 1'b0;
      bready = bp ? 1'($urandom_range(1)) : 1'b1;
      while (!(bvalid && bready)) begin
         @(negedge clk);
         bready = bp ? 1'($urandom_range(1)) : 1'b1;
      end
      compare("bresp", 64'(err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY), 64'(b.resp));
      @(negedge clk);
      bready = 1'b0;
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial begin
      logic [31:0] addr, addr2;
      int unsigned len, len2, n0;
      void'($urandom(SEED));
      {ar_ifu, ar_mem, aw, w} = '0;
      {arvalid_ifu, arvalid_mem, rready_ifu, rready_mem} = '0;
      {awvalid, wvalid, bready} = '0;
      {checks, errors, test_base, ifu_last_cyc, mem_first_cyc} = '0;
      rst = 1'b1;
      repeat (16) @(negedge clk);
      rst = 1'b0;
      compare("rvalid_ifu", 64'd0, 64'(rvalid_ifu));
      compare("rvalid_mem", 64'd0, 64'(rvalid_mem));
      compare("bvalid", 64'd0, 64'(bvalid));
      compare("arready_ifu", 64'd0, 64'(arready_ifu)); // Arbiter idle
      compare("arready_mem", 64'd0, 64'(arready_mem));
      compare("awready", 64'd1, 64'(awready));     // Write engine idle
      compare("wready", 64'd0, 64'(wready));
      end_test("reset");
      for (int i = 0; i < 4; i++)
         write_burst(32'(i * 2048), 255, 1'b0, 1'b1); // 256 words per burst
      end_test("fill");
      repeat (4) begin
         addr = 32'($urandom_range(DEPTH - 17) * 8);
         len  = $urandom_range(15);
         write_burst(addr, len, 1'b0, 1'b0);
         read_burst(1'b0, addr, len, 1'b0);
      end
      end_test("strobe");
      n0 = mem_rv_cnt;
      read_burst(1'b1, 32'($urandom_range(DEPTH - 17) * 8), $urandom_range(15), 1'b0);
      assert (mem_rv_cnt == n0) else begin
         $display("mem unit saw rvalid while a fetch burst ran alone");
         errors++;
      end
      end_test("fetch");
      addr  = 32'($urandom_range(DEPTH - 17) * 8);
      addr2 = 32'($urandom_range(DEPTH - 17) * 8);
      len   = $urandom_range(15);
      len2  = $urandom_range(15);
      mem_first_cyc = 0;
      fork                                   // Both raise arvalid on this edge
         read_burst(1'b1, addr, len, 1'b0);
         read_burst(1'b0, addr2, len2, 1'b0);
      join
      assert (mem_first_cyc > ifu_last_cyc) else begin
         $display("mem beat appeared before the fetch burst completed");
         errors++;
      end
      end_test("contention");
      repeat (2) begin
         addr = 32'($urandom_range(DEPTH - 17) * 8);
         len  = $urandom_range(15);
         write_burst(addr, len, 1'b1, 1'b0);
         read_burst(1'b0, addr, len, 1'b1);
      end
      read_burst(1'b1, addr, len, 1'b1);
      end_test("backpressure");
      read_burst(1'b0, 32'(DEPTH * 8), 3, 1'b0);
      write_burst(32'(DEPTH * 8), 1, 1'b0, 1'b0);
      write_burst(32'((DEPTH - 2) * 8), 3, 1'b0, 1'b0); // Two beats land, two drop
      read_burst(1'b1, 32'((DEPTH - 2) * 8), 3, 1'b0);
      end_test("range");
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   // Bounded by the longest possible burst traffic
   initial begin
      repeat (NUM_BURSTS * 256 * 4 + 1000) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", NUM_BURSTS * 256 * 4 + 1000);
      $display("TEST FAIL");
      $finish;
   end

endmodule

//--- list.f
+incdir+logic
logic/axi_pkg.sv
logic/ctrl_pkg.sv
logic/read_arbiter.sv
logic/sram_rd_engine.sv
logic/sram_wr_engine.sv
logic/sram_array.sv
logic/mem_subsys_top.sv
test/tb_clkgen.sv
test/read_arbiter_chk.sv
test/tb_top.sv

//--- run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
   -f list.f --top-module tb_top -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TEST FAIL" sim.log; then
   exit 1
fi
exit 0
